/* verilog/soc_io_pkg.sv */
`default_nettype none

package soc_io_pkg;

  localparam int apb_addr_width = 32;
  localparam int apb_data_width = 32;

  ////////////////////////////////////////////////////////////////////////////
  // address map

  localparam logic [apb_addr_width-1:0] clint_base_addr = 32'h1140_0000;
  localparam logic [apb_addr_width-1:0] clint_base_mask = 32'h0000_FFFF;

  localparam logic [apb_addr_width-1:0] plic_base_addr  = 32'h1100_0000;
  localparam logic [apb_addr_width-1:0] plic_base_mask  = 32'h003F_FFFF;

  ////////////////////////////////////////////////////////////////////////////
  // register offsets inside each window

  // clint, msip is one word per hart, mtimecmp two words per hart
  localparam logic [apb_addr_width-1:0] clint_msip_offset     = 32'h0000_0000;
  localparam logic [apb_addr_width-1:0] clint_mtimecmp_offset = 32'h0000_4000;
  localparam logic [apb_addr_width-1:0] clint_mtime_offset    = 32'h0000_BFF8;

  // plic
  localparam logic [apb_addr_width-1:0] plic_pending_offset   = 32'h0000_1000;
  localparam logic [apb_addr_width-1:0] plic_enable_offset    = 32'h0000_2000;
  localparam logic [apb_addr_width-1:0] plic_claim_offset     = 32'h0020_0004;

  // per-context spacing
  localparam logic [apb_addr_width-1:0] plic_enable_stride    = 32'h0000_0080;
  localparam logic [apb_addr_width-1:0] plic_context_stride   = 32'h0000_1000;

  ////////////////////////////////////////////////////////////////////////////
  // timer word

  // whole 64-bit value for the comparator, halves for the 32-bit bus
  // half[0] is the low word, half[1] the high word
  typedef union packed {
    logic [63:0]      word;
    logic [1:0][31:0] half;
  } timer_word_u;

endpackage

`default_nettype wire

/* verilog/io_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module io_decoder import soc_io_pkg::*; (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire [apb_addr_width-1:0]   paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire [apb_data_width-1:0]   clint_prdata_i,
  input  wire [apb_data_width-1:0]   plic_prdata_i,
  output logic                       clint_psel_o,
  output logic                       plic_psel_o,
  output logic [apb_data_width-1:0]  prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o
);

  logic clint_hit;
  logic plic_hit;
  logic access;

  // window match
  assign clint_hit = (paddr_i & ~clint_base_mask) == clint_base_addr;
  assign plic_hit  = (paddr_i & ~plic_base_mask) == plic_base_addr;

  assign access = psel_i & penable_i;

  assign clint_psel_o = psel_i & clint_hit;
  assign plic_psel_o  = psel_i & plic_hit;

  ////////////////////////////////////////////////////////////////////////////
  // response

  // read data of the selected target, zero if nothing matches
  always_comb begin
    prdata_o = '0;
    if (clint_hit) begin
      prdata_o = clint_prdata_i;
    end else if (plic_hit) begin
      prdata_o = plic_prdata_i;
    end
  end

  // no wait states
  assign pready_o = access;

  // error sink for unmapped addresses
  assign pslverr_o = access & ~(clint_hit | plic_hit);

  ////////////////////////////////////////////////////////////////////////////
  // checks

  // windows must not overlap
  a_one_target: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0({clint_psel_o, plic_psel_o})
  );

  a_penable_in_sel: assert property (
    @(posedge clk_i) disable iff (reset_i)
    penable_i |-> psel_i
  );

  // setup phase is always followed by its access phase
  a_setup_then_access: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (psel_i && !penable_i) |=> (psel_i && penable_i && $stable(paddr_i))
  );

endmodule

`default_nettype wire

/* verilog/clint.sv */
`timescale 1ns/10ps
`default_nettype none

module clint import soc_io_pkg::*; #(
  parameter int num_harts     = 2,
  parameter int timer_divider = 4
) (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire [apb_addr_width-1:0]   paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire [apb_data_width-1:0]   pwdata_i,
  output logic [apb_data_width-1:0]  prdata_o,
  output logic [num_harts-1:0]       irq_software_o,
  output logic [num_harts-1:0]       irq_timer_o
);

  localparam int prescale_width = $clog2(timer_divider + 1);
  localparam logic [apb_addr_width-1:0] mtime_hi_offset = clint_mtime_offset + 32'd4;

  logic [apb_addr_width-1:0] offset;
  logic                      wr_en;
  logic [prescale_width-1:0] prescale;
  logic                      tick;
  logic [num_harts-1:0]      msip;
  timer_word_u               mtime;
  timer_word_u               mtimecmp [num_harts];

  function automatic logic [apb_addr_width-1:0] msip_addr(input int h);
    return clint_msip_offset + apb_addr_width'(4 * h);
  endfunction

  // hi selects the upper half of the compare word
  function automatic logic [apb_addr_width-1:0] cmp_addr(input int h, input int hi);
    return clint_mtimecmp_offset + apb_addr_width'(8 * h + 4 * hi);
  endfunction

  assign offset = paddr_i & clint_base_mask;
  assign wr_en  = psel_i & penable_i & pwrite_i;
  assign tick   = prescale == prescale_width'(timer_divider - 1);

  ////////////////////////////////////////////////////////////////////////////
  // machine timer

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prescale   <= '0;
      mtime.word <= '0;
    end else begin
      if (tick) begin
        prescale   <= '0;
        mtime.word <= mtime.word + 64'd1;
      end else begin
        prescale <= prescale + 1'b1;
      end
      // bus write wins over the tick
      if (wr_en && offset == clint_mtime_offset) begin
        mtime.half[0] <= pwdata_i;
      end
      if (wr_en && offset == mtime_hi_offset) begin
        mtime.half[1] <= pwdata_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // per-hart registers

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      msip <= '0;
      for (int h = 0; h < num_harts; h++) begin
        mtimecmp[h].word <= '1;
      end
    end else if (wr_en) begin
      for (int h = 0; h < num_harts; h++) begin
        if (offset == msip_addr(h)) begin
          msip[h] <= pwdata_i[0];
        end
        if (offset == cmp_addr(h, 0)) begin
          mtimecmp[h].half[0] <= pwdata_i;
        end
        if (offset == cmp_addr(h, 1)) begin
          mtimecmp[h].half[1] <= pwdata_i;
        end
      end
    end
  end

  // read mux
  always_comb begin
    prdata_o = '0;
    if (offset == clint_mtime_offset) begin
      prdata_o = mtime.half[0];
    end
    if (offset == mtime_hi_offset) begin
      prdata_o = mtime.half[1];
    end
    for (int h = 0; h < num_harts; h++) begin
      if (offset == msip_addr(h)) begin
        prdata_o = apb_data_width'(msip[h]);
      end
      if (offset == cmp_addr(h, 0)) begin
        prdata_o = mtimecmp[h].half[0];
      end
      if (offset == cmp_addr(h, 1)) begin
        prdata_o = mtimecmp[h].half[1];
      end
    end
  end

  // comparators
  always_comb begin
    for (int h = 0; h < num_harts; h++) begin
      irq_timer_o[h] = mtime.word >= mtimecmp[h].word;
    end
  end

  assign irq_software_o = msip;

  a_prescale_range: assert property (
    @(posedge clk_i) disable iff (reset_i)
    prescale < timer_divider
  );

endmodule

`default_nettype wire

/* verilog/plic.sv */
`timescale 1ns/10ps
`default_nettype none

module plic import soc_io_pkg::*; #(
  parameter int num_harts = 2,
  parameter int num_irqs  = 8
) (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire [apb_addr_width-1:0]   paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire [apb_data_width-1:0]   pwdata_i,
  input  wire [num_irqs-1:0]         sources_i,
  output logic [apb_data_width-1:0]  prdata_o,
  output logic [num_harts-1:0]       irq_external_o
);

  localparam int id_width = $clog2(num_irqs);

  logic [apb_addr_width-1:0]          offset;
  logic                               rd_en;
  logic                               wr_en;
  logic [num_irqs-1:0]                valid_src;
  logic [num_irqs-1:0]                pending;
  logic [num_irqs-1:0]                in_service;
  logic [num_harts-1:0][num_irqs-1:0] enable;
  logic [num_harts-1:0][id_width-1:0] claim_id;
  logic [num_harts-1:0]               claim_rd;
  logic [num_harts-1:0]               complete_wr;

  // lowest set bit above source 0 or zero if none
  function automatic logic [id_width-1:0] lowest_id(input logic [num_irqs-1:0] vec);
    logic [id_width-1:0] id;
    id = '0;
    for (int s = num_irqs - 1; s > 0; s--) begin
      if (vec[s]) begin
        id = id_width'(s);
      end
    end
    return id;
  endfunction

  function automatic logic [apb_addr_width-1:0] enable_addr(input int c);
    return plic_enable_offset + plic_enable_stride * apb_addr_width'(c);
  endfunction

  function automatic logic [apb_addr_width-1:0] claim_addr(input int c);
    return plic_claim_offset + plic_context_stride * apb_addr_width'(c);
  endfunction

  assign offset = paddr_i & plic_base_mask;
  assign rd_en  = psel_i & penable_i & ~pwrite_i;
  assign wr_en  = psel_i & penable_i & pwrite_i;

  // source 0 is reserved
  assign valid_src = {sources_i[num_irqs-1:1], 1'b0};

  always_comb begin
    for (int c = 0; c < num_harts; c++) begin
      claim_id[c]       = lowest_id(pending & enable[c]);
      irq_external_o[c] = |(pending & enable[c]);
      claim_rd[c]       = rd_en && offset == claim_addr(c);
      complete_wr[c]    = wr_en && offset == claim_addr(c);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // gateways, claim and complete

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending    <= '0;
      in_service <= '0;
      enable     <= '0;
    end else begin
      // level sources re-arm only once completed
      pending <= pending | (valid_src & ~in_service);
      for (int c = 0; c < num_harts; c++) begin
        if (claim_rd[c] && claim_id[c] != '0) begin
          pending[claim_id[c]]    <= 1'b0;
          in_service[claim_id[c]] <= 1'b1;
        end
        if (complete_wr[c] && pwdata_i < num_irqs) begin
          in_service[pwdata_i[id_width-1:0]] <= 1'b0;
        end
        if (wr_en && offset == enable_addr(c)) begin
          enable[c] <= {pwdata_i[num_irqs-1:1], 1'b0};
        end
      end
    end
  end

  // read mux
  always_comb begin
    prdata_o = '0;
    if (offset == plic_pending_offset) begin
      prdata_o = apb_data_width'(pending);
    end
    for (int c = 0; c < num_harts; c++) begin
      if (offset == enable_addr(c)) begin
        prdata_o = apb_data_width'(enable[c]);
      end
      if (offset == claim_addr(c)) begin
        prdata_o = apb_data_width'(claim_id[c]);
      end
    end
  end

  for (genvar c = 0; c < num_harts; c++) begin : g_claim_chk
    a_claim_range: assert property (
      @(posedge clk_i) disable iff (reset_i)
      claim_rd[c] |-> claim_id[c] < num_irqs
    );
  end

endmodule

`default_nettype wire

/* verilog/soc_io_top.sv */
`timescale 1ns/10ps
`default_nettype none

module soc_io_top import soc_io_pkg::*; #(
  parameter int num_harts     = 2,
  parameter int num_irqs      = 8,
  parameter int timer_divider = 4
) (
  input  wire                        clk_i,
  input  wire                        reset_i,
  input  wire [apb_addr_width-1:0]   paddr_i,
  input  wire                        psel_i,
  input  wire                        penable_i,
  input  wire                        pwrite_i,
  input  wire [apb_data_width-1:0]   pwdata_i,
  input  wire                        irq_uart_i,
  input  wire                        irq_sd_i,
  output logic [apb_data_width-1:0]  prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  output logic [num_harts-1:0]       irq_software_o,
  output logic [num_harts-1:0]       irq_timer_o,
  output logic [num_harts-1:0]       irq_external_o
);

  logic                      clint_psel;
  logic                      plic_psel;
  logic [apb_data_width-1:0] clint_prdata;
  logic [apb_data_width-1:0] plic_prdata;
  logic [num_irqs-1:0]       irq_sources;

  ////////////////////////////////////////////////////////////////////////////
  // address decode

  io_decoder u_decoder (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .clint_prdata_i (clint_prdata),
    .plic_prdata_i  (plic_prdata),
    .clint_psel_o   (clint_psel),
    .plic_psel_o    (plic_psel),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clint and plic

  clint #(
    .num_harts     (num_harts),
    .timer_divider (timer_divider)
  ) u_clint (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .paddr_i        (paddr_i),
    .psel_i         (clint_psel),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (clint_prdata),
    .irq_software_o (irq_software_o),
    .irq_timer_o    (irq_timer_o)
  );

  // uart on source 1, sd on source 2, both level
  assign irq_sources = {{(num_irqs - 3){1'b0}}, irq_sd_i, irq_uart_i, 1'b0};

  plic #(
    .num_harts (num_harts),
    .num_irqs  (num_irqs)
  ) u_plic (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .paddr_i        (paddr_i),
    .psel_i         (plic_psel),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .sources_i      (irq_sources),
    .prdata_o       (plic_prdata),
    .irq_external_o (irq_external_o)
  );

endmodule

`default_nettype wire

/* verification/tb_soc_io.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_io;

  localparam int num_harts = 2;
  localparam int max_steps = 256;
  localparam int num_fields = 11;

  logic                 clk_i;
  logic                 reset_i;
  logic [31:0]          paddr_i;
  logic                 psel_i;
  logic                 penable_i;
  logic                 pwrite_i;
  logic [31:0]          pwdata_i;
  logic                 irq_uart_i;
  logic                 irq_sd_i;
  logic [31:0]          prdata_o;
  logic                 pready_o;
  logic                 pslverr_o;
  logic [num_harts-1:0] irq_software_o;
  logic [num_harts-1:0] irq_timer_o;
  logic [num_harts-1:0] irq_external_o;

  // one entry per stim line
  int          s_line  [max_steps];
  int          s_test  [max_steps];
  logic [15:0] s_op    [max_steps];
  logic [31:0] s_addr  [max_steps];
  logic [31:0] s_wdata [max_steps];
  logic        s_uart  [max_steps];
  logic        s_sd    [max_steps];
  logic [31:0] s_rdata [max_steps];
  logic        s_err   [max_steps];
  logic [1:0]  s_sw    [max_steps];
  logic [1:0]  s_tmr   [max_steps];
  logic [1:0]  s_ext   [max_steps];

  int          n_steps = 0;
  int          line_count = 0;
  int          errors = 0;
  int          test_errors = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic [31:0] last_count = '0;

  soc_io_top #(
    .num_harts     (num_harts),
    .num_irqs      (8),
    .timer_divider (4)
  ) uut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .irq_uart_i     (irq_uart_i),
    .irq_sd_i       (irq_sd_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .irq_software_o (irq_software_o),
    .irq_timer_o    (irq_timer_o),
    .irq_external_o (irq_external_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the stim steps did not complete", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got %h expected %h", $time, what, actual, expected);
      errors++;
      test_errors++;
    end
  endtask

  task automatic load_stim();
    int             fd;
    int             n;
    int             t;
    int             uart;
    int             sd;
    int             err;
    logic [31:0]    tok;
    logic [31:0]    addr;
    logic [31:0]    wdata;
    logic [31:0]    rdata;
    logic [31:0]    sw;
    logic [31:0]    tmr;
    logic [31:0]    ext;
    logic [8*160-1:0] line;
    fd = $fopen("verification/soc_io_stim.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/soc_io_stim.txt for reading");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      line_count++;
      n = $sscanf(line, "%d %s %h %h %d %d %h %d %h %h %h",
                  t, tok, addr, wdata, uart, sd, rdata, err, sw, tmr, ext);
      // comment and blank lines match no field
      if (n > 0 && n < num_fields) begin
        $display("stim line %0d is short, found %0d of %0d fields", line_count, n,
                 num_fields);
        errors++;
      end else if (n == num_fields && n_steps < max_steps) begin
        s_line[n_steps]  = line_count;
        s_test[n_steps]  = t;
        s_op[n_steps]    = tok[15:0];
        s_addr[n_steps]  = addr;
        s_wdata[n_steps] = wdata;
        s_uart[n_steps]  = uart[0];
        s_sd[n_steps]    = sd[0];
        s_rdata[n_steps] = rdata;
        s_err[n_steps]   = err[0];
        s_sw[n_steps]    = sw[1:0];
        s_tmr[n_steps]   = tmr[1:0];
        s_ext[n_steps]   = ext[1:0];
        n_steps++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one stim step, entered 1 ns after a rising edge

  task automatic run_step(input int i);
    logic  is_apb;
    string where;
    where  = $sformatf("stim line %0d", s_line[i]);
    is_apb = s_op[i] != "id";
    if (is_apb && s_op[i] != "wr" && s_op[i] != "rd" && s_op[i] != "rm") begin
      $display("stim line %0d has an unknown operation", s_line[i]);
      errors++;
      test_errors++;
    end
    irq_uart_i = s_uart[i];
    irq_sd_i   = s_sd[i];
    if (is_apb) begin
      paddr_i   = s_addr[i];
      pwrite_i  = s_op[i] == "wr";
      pwdata_i  = s_wdata[i];
      psel_i    = 1'b1;
      penable_i = 1'b0;
    end
    @(posedge clk_i);
    #1;
    if (is_apb) begin
      penable_i = 1'b1;
      @(negedge clk_i);
      check_value(pready_o, 1, {where, " pready_o"});
      check_value(pslverr_o, s_err[i], {where, " pslverr_o"});
      if (s_op[i] == "rd" || s_err[i]) begin
        check_value(prdata_o, s_rdata[i], {where, " prdata_o"});
      end
      // free-running counter, only its order is known
      if (s_op[i] == "rm") begin
        check_value(prdata_o >= last_count, 1, {where, " counter went backwards"});
        last_count = prdata_o;
      end
      @(posedge clk_i);
      #1;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      pwrite_i  = 1'b0;
    end
    @(negedge clk_i);
    check_value(irq_software_o, s_sw[i], {where, " irq_software_o"});
    check_value(irq_timer_o, s_tmr[i], {where, " irq_timer_o"});
    check_value(irq_external_o, s_ext[i], {where, " irq_external_o"});
    @(posedge clk_i);
    #1;
  endtask

  task automatic finish_test(input int num);
    if (test_errors == 0) begin
      $display("test %0d passed", num);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", num, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  initial begin
    int i;
    reset_i    = 1'b1;
    paddr_i    = '0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    pwrite_i   = 1'b0;
    pwdata_i   = '0;
    irq_uart_i = 1'b0;
    irq_sd_i   = 1'b0;
    load_stim();
    if (n_steps == 0) begin
      $display("no usable steps in the stim file");
      errors++;
    end
    cycle_limit = 4 * line_count + 50;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (i = 0; i < n_steps; i++) begin
      if (i > 0 && s_test[i] != s_test[i-1]) begin
        finish_test(s_test[i-1]);
      end
      run_step(i);
    end
    if (n_steps > 0) begin
      finish_test(s_test[n_steps-1]);
    end
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/soc_io_stim.txt */
# test op addr wdata uart sd exp_rdata exp_err exp_sw exp_tmr exp_ext (hex except test, uart, sd, err)
# op: wr write, rd read, rm read of a counter that must not go back, id idle
1 rd 20000000 00000000 0 0 00000000 1 0 0 0
1 wr 20000000 deadbeef 0 0 00000000 1 0 0 0
1 rd 00000000 00000000 0 0 00000000 1 0 0 0
1 rd 11002000 00000000 0 0 00000000 0 0 0 0
2 wr 11400000 00000001 0 0 00000000 0 1 0 0
2 rd 11400000 00000000 0 0 00000001 0 1 0 0
2 wr 11400004 00000001 0 0 00000000 0 3 0 0
2 wr 11400000 00000000 0 0 00000000 0 2 0 0
2 rd 11400000 00000000 0 0 00000000 0 2 0 0
2 wr 11400004 00000000 0 0 00000000 0 0 0 0
3 rm 1140bff8 00000000 0 0 00000000 0 0 0 0
3 rm 1140bff8 00000000 0 0 00000000 0 0 0 0
3 wr 11404000 00000000 0 0 00000000 0 0 0 0
3 wr 11404004 00000000 0 0 00000000 0 0 1 0
3 rd 11404004 00000000 0 0 00000000 0 0 1 0
3 wr 11404004 ffffffff 0 0 00000000 0 0 0 0
3 wr 11404000 ffffffff 0 0 00000000 0 0 0 0
3 rd 11404000 00000000 0 0 ffffffff 0 0 0 0
3 wr 1140400c 00000000 0 0 00000000 0 0 0 0
3 wr 11404008 00000000 0 0 00000000 0 0 2 0
3 wr 1140400c ffffffff 0 0 00000000 0 0 0 0
3 rm 1140bff8 00000000 0 0 00000000 0 0 0 0
4 wr 11002000 00000002 0 0 00000000 0 0 0 0
4 id 00000000 00000000 1 0 00000000 0 0 0 1
4 rd 11001000 00000000 1 0 00000002 0 0 0 1
4 rd 11200004 00000000 1 0 00000001 0 0 0 0
4 rd 11200004 00000000 1 0 00000000 0 0 0 0
4 wr 11200004 00000001 0 0 00000000 0 0 0 0
5 wr 11002000 00000006 1 1 00000000 0 0 0 1
5 rd 11200004 00000000 1 1 00000001 0 0 0 1
5 wr 11200004 00000001 0 1 00000000 0 0 0 1
5 rd 11200004 00000000 0 1 00000002 0 0 0 0
5 rd 11001000 00000000 0 1 00000000 0 0 0 0
5 wr 11200004 00000002 0 0 00000000 0 0 0 0
5 id 00000000 00000000 0 0 00000000 0 0 0 0
6 wr 11002000 00000000 0 0 00000000 0 0 0 0
6 wr 11002080 00000004 0 0 00000000 0 0 0 0
6 id 00000000 00000000 1 1 00000000 0 0 0 2
6 rd 11001000 00000000 1 1 00000006 0 0 0 2
6 rd 11201004 00000000 1 1 00000002 0 0 0 0
6 rd 11001000 00000000 1 1 00000002 0 0 0 0

/* list.f */
verilog/soc_io_pkg.sv
verilog/io_decoder.sv
verilog/clint.sv
verilog/plic.sv
verilog/soc_io_top.sv
verification/tb_soc_io.sv
